// ==== rom_loader.f ====
+incdir+rtl
rtl/ioctl_pkg.sv
rtl/mem_pkg.sv
rtl/mem_write_if.sv
rtl/ioctl_decoder.sv
rtl/rom_store.sv
rtl/nvram_buffer.sv
rtl/core_reset_gen.sv
rtl/rom_loader_top.sv
dv/rom_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the rom loader testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	--top-module rom_loader_tb -f rom_loader.f -o rom_loader_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/rom_loader_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

// ==== dv/rom_loader_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module rom_loader_tb
	import ioctl_pkg::*;
	import mem_pkg::*;
();
	typedef enum logic [2:0] {K_WRITE, K_PRG_READ, K_GFX_READ, K_NV_READ, K_CONTROL} step_kind_t;

	typedef struct packed {
		step_kind_t   kind;
		ioctl_index_t index;
		ioctl_addr_t  addr;
		ioctl_byte_t  data;
		word_t        exp;
	} step_t;

	localparam int NSTEPS = 31;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// kind, index, address, byte, expected.
	// control byte is {download, status_reset, button_reset}.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam step_t STEPS [NSTEPS] = '{
		'{K_CONTROL,  8'h00, 25'h00000, 8'h00, 16'h0001}, // idle, held in reset.
		'{K_CONTROL,  8'h00, 25'h00000, 8'h04, 16'h0001}, // download running.
		'{K_WRITE,    8'h00, 25'h00000, 8'h34, 16'h0000},
		'{K_WRITE,    8'h00, 25'h00001, 8'h12, 16'h0000},
		'{K_PRG_READ, 8'h00, 25'h00000, 8'h00, 16'h1234},
		'{K_WRITE,    8'h00, 25'h00001, 8'hab, 16'h0000}, // high half only.
		'{K_PRG_READ, 8'h00, 25'h00000, 8'h00, 16'hab34},
		'{K_WRITE,    8'h00, 25'h00002, 8'h78, 16'h0000},
		'{K_WRITE,    8'h00, 25'h00003, 8'h56, 16'h0000},
		'{K_PRG_READ, 8'h00, 25'h00001, 8'h00, 16'h5678},
		'{K_WRITE,    8'h00, 25'h10000, 8'hcd, 16'h0000}, // graphics region.
		'{K_WRITE,    8'h00, 25'h10001, 8'hef, 16'h0000},
		'{K_GFX_READ, 8'h00, 25'h00000, 8'h00, 16'hefcd},
		'{K_PRG_READ, 8'h00, 25'h00000, 8'h00, 16'hab34},
		'{K_WRITE,    8'h00, 25'h20000, 8'h11, 16'h0000}, // past both regions.
		'{K_PRG_READ, 8'h00, 25'h00000, 8'h00, 16'hab34},
		'{K_GFX_READ, 8'h00, 25'h00000, 8'h00, 16'hefcd},
		'{K_WRITE,    8'hff, 25'h00003, 8'h5a, 16'h0000},
		'{K_NV_READ,  8'h00, 25'h00003, 8'h00, 16'h005a},
		'{K_WRITE,    8'h05, 25'h00003, 8'h99, 16'h0000}, // foreign index.
		'{K_NV_READ,  8'h00, 25'h00003, 8'h00, 16'h005a},
		'{K_WRITE,    8'h05, 25'h00000, 8'h99, 16'h0000},
		'{K_WRITE,    8'hff, 25'h00000, 8'h77, 16'h0000},
		'{K_PRG_READ, 8'h00, 25'h00000, 8'h00, 16'hab34},
		'{K_NV_READ,  8'h00, 25'h00000, 8'h00, 16'h0077},
		'{K_CONTROL,  8'h00, 25'h00000, 8'h00, 16'h0000}, // download ends.
		'{K_CONTROL,  8'h00, 25'h00000, 8'h02, 16'h0001},
		'{K_CONTROL,  8'h00, 25'h00000, 8'h00, 16'h0000},
		'{K_CONTROL,  8'h00, 25'h00000, 8'h01, 16'h0001},
		'{K_CONTROL,  8'h00, 25'h00000, 8'h00, 16'h0000},
		'{K_CONTROL,  8'h00, 25'h00000, 8'h04, 16'h0000}  // loaded stays sticky.
	};

	logic         clk_sd;
	logic         rst;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	ioctl_byte_t  ioctl_dout;
	ioctl_byte_t  ioctl_din;
	logic         status_reset;
	logic         button_reset;
	logic         core_reset;
	logic         loader_busy;
	prg_addr_t    prg_addr;
	word_t        prg_q;
	gfx_addr_t    gfx_addr;
	word_t        gfx_q;

	word_t prg_model [1 << `LOADER_PRG_AW];
	word_t gfx_model [1 << `LOADER_GFX_AW];

	rom_loader_top rom_loader_inst (
		.clk_sd         (clk_sd),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_din      (ioctl_din),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.core_reset     (core_reset),
		.loader_busy    (loader_busy),
		.prg_addr       (prg_addr),
		.prg_q          (prg_q),
		.gfx_addr       (gfx_addr),
		.gfx_q          (gfx_q)
	);

	initial begin
		clk_sd = 1'b0;
		forever #10 clk_sd = ~clk_sd;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t merge_byte(input word_t old, input logic hi, input ioctl_byte_t b);
		word_t m;
		m = old;
		if (hi)
			m[15:8] = b;
		else
			m[7:0] = b;
		return m;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_byte(input string name, input ioctl_byte_t got, input ioctl_byte_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk_sd);
		while (loader_busy !== 1'b0) begin
			@(negedge clk_sd);
			n++;
			if (n > 20) begin
				$display("loader_busy did not fall after a host write");
				$display("Errors found");
				$fatal(1);
			end
		end
	endtask

	// one strobe, then the minimum gap the host must keep.
	task automatic host_write(input ioctl_index_t idx, input ioctl_addr_t a, input ioctl_byte_t b);
		int w;
		logic img;
		w = int'(a[`LOADER_PRG_AW:1]);
		img = (idx == 8'h00) && ioctl_download && (a[`LOADER_IOCTL_AW-1:17] == '0);
		@(posedge clk_sd);
		ioctl_index <= idx;
		ioctl_addr <= a;
		ioctl_dout <= b;
		ioctl_wr <= 1'b1;
		@(posedge clk_sd);
		ioctl_wr <= 1'b0;
		@(negedge clk_sd);
		check_bit("loader_busy", loader_busy, img); // only image bytes raise a request.
		repeat (`LOADER_MIN_WR_GAP) @(posedge clk_sd);
		wait_idle();
		if (img) begin
			if (a[`LOADER_GFX_SEL_BIT])
				gfx_model[w] = merge_byte(gfx_model[w], a[0], b);
			else
				prg_model[w] = merge_byte(prg_model[w], a[0], b);
		end
	endtask

	task automatic read_prg(input prg_addr_t a, input word_t exp);
		@(posedge clk_sd);
		prg_addr <= a;
		@(posedge clk_sd);
		@(negedge clk_sd);
		check_word("prg_q", prg_q, exp);
	endtask

	task automatic read_gfx(input gfx_addr_t a, input word_t exp);
		@(posedge clk_sd);
		gfx_addr <= a;
		@(posedge clk_sd);
		@(negedge clk_sd);
		check_word("gfx_q", gfx_q, exp);
	endtask

	task automatic read_nv(input nv_addr_t a, input ioctl_byte_t exp);
		@(posedge clk_sd);
		ioctl_addr <= ioctl_addr_t'(a);
		@(posedge clk_sd);
		@(negedge clk_sd);
		check_byte("ioctl_din", ioctl_din, exp);
	endtask

	// registered reset output settles two edges after the inputs.
	task automatic set_controls(input ioctl_byte_t c, input logic exp);
		@(posedge clk_sd);
		ioctl_download <= c[2];
		status_reset <= c[1];
		button_reset <= c[0];
		repeat (2) @(posedge clk_sd);
		@(negedge clk_sd);
		check_bit("core_reset", core_reset, exp);
		check_bit("loader_busy", loader_busy, 1'b0);
	endtask

	task automatic apply_step(input step_t s);
		case (s.kind)
			K_WRITE:    host_write(s.index, s.addr, s.data);
			K_PRG_READ: read_prg(prg_addr_t'(s.addr), s.exp);
			K_GFX_READ: read_gfx(gfx_addr_t'(s.addr), s.exp);
			K_NV_READ:  read_nv(nv_addr_t'(s.addr), ioctl_byte_t'(s.exp));
			default:    set_controls(s.data, s.exp[0]);
		endcase
	endtask

	initial begin
		logic [31:0] rng;
		ioctl_addr_t a;
		rng = 32'hecf4_b857;
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		prg_addr = '0;
		gfx_addr = '0;
		repeat (3) @(posedge clk_sd);
		rst <= 1'b0;

		for (int i = 0; i < NSTEPS; i++)
			apply_step(STEPS[i]);

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// random stream over the first eight words of each bank
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < 32; i++) begin
			rng = xorshift(rng);
			a = '0;
			a[3:0] = 4'(i);
			a[`LOADER_GFX_SEL_BIT] = i[4];
			host_write(8'h00, a, rng[7:0]); // both halves known.
		end
		for (int i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			a = '0;
			a[3:0] = rng[3:0];
			a[`LOADER_GFX_SEL_BIT] = rng[8];
			host_write(8'h00, a, rng[23:16]);
		end
		for (int w = 0; w < 8; w++) begin
			read_prg(prg_addr_t'(w), prg_model[w]);
			read_gfx(gfx_addr_t'(w), gfx_model[w]);
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/rom_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module rom_loader_top
	import ioctl_pkg::*;
	import mem_pkg::*;
(
	input  logic         clk_sd,
	input  logic         rst,
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  logic         ioctl_wr,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_byte_t  ioctl_dout,
	output ioctl_byte_t  ioctl_din,
	input  logic         status_reset,
	input  logic         button_reset,
	output logic         core_reset,
	output logic         loader_busy,
	input  prg_addr_t    prg_addr,
	output word_t        prg_q,
	input  gfx_addr_t    gfx_addr,
	output word_t        gfx_q
);
	logic nv_we;

	mem_write_if prg_wr();
	mem_write_if gfx_wr();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// download path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	ioctl_decoder decoder_inst (
		.clk_sd   (clk_sd),
		.rst      (rst),
		.download (ioctl_download),
		.index    (ioctl_index),
		.wr       (ioctl_wr),
		.addr     (ioctl_addr),
		.dout     (ioctl_dout),
		.nv_we    (nv_we),
		.busy     (loader_busy),
		.prg_wr   (prg_wr.source),
		.gfx_wr   (gfx_wr.source)
	);

	rom_store store_inst (
		.clk_sd   (clk_sd),
		.rst      (rst),
		.prg_addr (prg_addr),
		.gfx_addr (gfx_addr),
		.prg_wr   (prg_wr.sink),
		.gfx_wr   (gfx_wr.sink),
		.prg_q    (prg_q),
		.gfx_q    (gfx_q)
	);

	nvram_buffer nvram_inst (
		.clk_sd (clk_sd),
		.we     (nv_we),
		.addr   (ioctl_addr[`LOADER_NV_AW-1:0]), // low byte address.
		.d      (ioctl_dout),
		.q      (ioctl_din)
	);

	core_reset_gen reset_inst (
		.clk_sd       (clk_sd),
		.rst          (rst),
		.download     (ioctl_download),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.core_reset   (core_reset)
	);

endmodule

`default_nettype wire

// ==== rtl/core_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module core_reset_gen (
	input  logic clk_sd,
	input  logic rst,
	input  logic download,
	input  logic status_reset,
	input  logic button_reset,
	output logic core_reset
);
	logic download_q;
	logic rom_loaded;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			download_q <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_q <= download;
			if (download_q && !download)
				rom_loaded <= 1'b1; // sticky until rst.
			core_reset <= status_reset | button_reset | ~rom_loaded;
		end
	end

	a_hold_until_loaded: assert property (@(posedge clk_sd) disable iff (rst)
		!rom_loaded |-> core_reset)
		else $error("game core left reset before the image loaded");

endmodule

`default_nettype wire

// ==== rtl/nvram_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module nvram_buffer
	import ioctl_pkg::*;
	import mem_pkg::*;
(
	input  logic        clk_sd,
	input  logic        we,
	input  nv_addr_t    addr,
	input  ioctl_byte_t d,
	output ioctl_byte_t q
);
	localparam int NV_BYTES = 1 << `LOADER_NV_AW;

	ioctl_byte_t mem [NV_BYTES];

	// host writes on index 8'hff.
	always_ff @(posedge clk_sd) begin
		if (we)
			mem[addr] <= d;
	end

	// read-back for upload, one clock late.
	always_ff @(posedge clk_sd) begin
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== rtl/rom_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module rom_store
	import mem_pkg::*;
(
	input  logic       clk_sd,
	input  logic       rst,
	input  prg_addr_t  prg_addr,
	input  gfx_addr_t  gfx_addr,
	mem_write_if.sink  prg_wr,
	mem_write_if.sink  gfx_wr,
	output word_t      prg_q,
	output word_t      gfx_q
);
	localparam int PRG_WORDS = 1 << `LOADER_PRG_AW;
	localparam int GFX_WORDS = 1 << `LOADER_GFX_AW;

	word_t        prg_mem [PRG_WORDS];
	word_t        gfx_mem [GFX_WORDS];
	store_state_t state;
	logic         prg_pend;
	logic         gfx_pend;
	prg_addr_t    prg_wa;
	gfx_addr_t    gfx_wa;

	assign prg_pend = (prg_wr.req != prg_wr.ack);
	assign gfx_pend = (gfx_wr.req != gfx_wr.ack);
	assign prg_wa = prg_wr.addr[`LOADER_PRG_AW-1:0];
	assign gfx_wa = gfx_wr.addr[`LOADER_GFX_AW-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write arbiter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			state <= ST_IDLE;
			prg_wr.ack <= 1'b0;
			gfx_wr.ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (prg_pend)
						state <= ST_PRG; // program first.
					else if (gfx_pend)
						state <= ST_GFX;
				end
				ST_PRG: begin
					prg_wr.ack <= ~prg_wr.ack;
					state <= ST_IDLE;
				end
				ST_GFX: begin
					gfx_wr.ack <= ~gfx_wr.ack;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// byte lanes merge under ds.
	always_ff @(posedge clk_sd) begin
		if (state == ST_PRG) begin
			if (prg_wr.ds[0])
				prg_mem[prg_wa][7:0] <= prg_wr.d[7:0];
			if (prg_wr.ds[1])
				prg_mem[prg_wa][15:8] <= prg_wr.d[15:8];
		end
		if (state == ST_GFX) begin
			if (gfx_wr.ds[0])
				gfx_mem[gfx_wa][7:0] <= gfx_wr.d[7:0];
			if (gfx_wr.ds[1])
				gfx_mem[gfx_wa][15:8] <= gfx_wr.d[15:8];
		end
	end

	// game side reads, never blocked.
	always_ff @(posedge clk_sd) begin
		prg_q <= prg_mem[prg_addr];
		gfx_q <= gfx_mem[gfx_addr];
	end

	a_ds_valid: assert property (@(posedge clk_sd) disable iff (rst)
		(state != ST_IDLE) |->
		(((state == ST_PRG) ? prg_wr.ds : gfx_wr.ds) != 2'b00))
		else $error("store write with no byte selected");

endmodule

`default_nettype wire

// ==== rtl/ioctl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "loader_cfg.svh"

module ioctl_decoder
	import ioctl_pkg::*;
	import mem_pkg::*;
(
	input  logic         clk_sd,
	input  logic         rst,
	input  logic         download,
	input  ioctl_index_t index,
	input  logic         wr,
	input  ioctl_addr_t  addr,
	input  ioctl_byte_t  dout,
	output logic         nv_we,
	output logic         busy,
	mem_write_if.source  prg_wr,
	mem_write_if.source  gfx_wr
);
	index_kind_t kind;
	logic        wr_q;
	logic        wr_edge;
	logic        img_ok;
	logic        to_gfx;
	logic        prg_idle;
	logic        gfx_idle;
	logic        prg_go;
	logic        gfx_go;

	always_comb begin
		case (index)
			8'h00:   kind = INDEX_ROM;
			8'hff:   kind = INDEX_NVRAM;
			default: kind = INDEX_OTHER;
		endcase
	end

	assign wr_edge = wr & ~wr_q;
	// bytes past the graphics region are dropped.
	assign img_ok = download && (kind == INDEX_ROM) &&
		(addr[`LOADER_IOCTL_AW-1:`LOADER_GFX_SEL_BIT+1] == '0);
	assign to_gfx = addr[`LOADER_GFX_SEL_BIT];

	assign prg_idle = (prg_wr.req == prg_wr.ack);
	assign gfx_idle = (gfx_wr.req == gfx_wr.ack);
	assign prg_go = wr_edge && img_ok && !to_gfx && prg_idle;
	assign gfx_go = wr_edge && img_ok && to_gfx && gfx_idle;

	assign nv_we = wr_edge && (kind == INDEX_NVRAM);
	assign busy = !prg_idle || !gfx_idle;

	always_ff @(posedge clk_sd) begin
		if (rst) begin
			wr_q <= 1'b0;
			prg_wr.req <= 1'b0;
			gfx_wr.req <= 1'b0;
		end else begin
			wr_q <= wr;
			if (prg_go)
				prg_wr.req <= ~prg_wr.req;
			if (gfx_go)
				gfx_wr.req <= ~gfx_wr.req;
		end
	end

	// payload held until the matching ack.
	always_ff @(posedge clk_sd) begin
		if (prg_go) begin
			prg_wr.addr <= word_addr_t'(addr >> 1);
			prg_wr.ds <= {addr[0], ~addr[0]};
			prg_wr.d <= {dout, dout};
		end
		if (gfx_go) begin
			gfx_wr.addr <= word_addr_t'(addr >> 1); // region bit drops off.
			gfx_wr.ds <= {addr[0], ~addr[0]};
			gfx_wr.d <= {dout, dout};
		end
	end

	// host must not outrun the store.
	a_no_overrun: assert property (@(posedge clk_sd) disable iff (rst)
		(wr_edge && img_ok) |-> (to_gfx ? gfx_idle : prg_idle))
		else $error("image byte arrived while its store port was busy");

endmodule

`default_nettype wire

// ==== rtl/mem_write_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one word write, requested by toggling req.
// pending while req != ack.
interface mem_write_if
	import mem_pkg::*;
();
	logic       req;
	logic       ack;
	word_addr_t addr;
	byte_sel_t  ds;
	word_t      d;

	modport source (output req, output addr, output ds, output d, input ack);

	modport sink (input req, input addr, input ds, input d, output ack);

endinterface

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

`include "loader_cfg.svh"

package mem_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word stores and nvram
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int WORD_AW = (`LOADER_PRG_AW > `LOADER_GFX_AW) ?
		`LOADER_PRG_AW : `LOADER_GFX_AW;

	typedef logic [15:0]               word_t;
	typedef logic [1:0]                byte_sel_t; // bit 1 is the high byte.
	typedef logic [`LOADER_PRG_AW-1:0] prg_addr_t;
	typedef logic [`LOADER_GFX_AW-1:0] gfx_addr_t;
	typedef logic [WORD_AW-1:0]        word_addr_t; // banks use the low bits.
	typedef logic [`LOADER_NV_AW-1:0]  nv_addr_t;

	typedef enum logic [1:0] {ST_IDLE, ST_PRG, ST_GFX} store_state_t;

endpackage

`default_nettype wire

// ==== rtl/ioctl_pkg.sv ====
`default_nettype none

`include "loader_cfg.svh"

package ioctl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// host download bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`LOADER_IOCTL_AW-1:0] ioctl_addr_t; // byte address.
	typedef logic [7:0]                  ioctl_byte_t;
	typedef logic [7:0]                  ioctl_index_t;

	// what a download index carries.
	typedef enum logic [1:0] {
		INDEX_ROM,   // index 0, game image.
		INDEX_NVRAM, // index 8'hff.
		INDEX_OTHER
	} index_kind_t;

endpackage

`default_nettype wire

// ==== rtl/loader_cfg.svh ====
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// download bus and store geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define LOADER_IOCTL_AW    25 // host byte address.
`define LOADER_PRG_AW      10 // program bank, words.
`define LOADER_GFX_AW      10 // graphics bank, words.
`define LOADER_NV_AW       9  // nvram, bytes.

// bit 16 of the byte address picks the graphics region.
`define LOADER_GFX_SEL_BIT 16
`define LOADER_MIN_WR_GAP  4  // clocks between host strobes.

`endif
